// File: rtl/rsa_defines.svh
`ifndef RSA_DEFINES_SVH
`define RSA_DEFINES_SVH

// operand width for text, exponent, modulus and result
`define RSA_W 256

// bit and iteration counters, wide enough to hold a count of 256
`define RSA_CNT_W 9

`endif

// File: rtl/rsa_state_pkg.sv
package rsa_state_pkg;

	// exponent sequencer
	typedef enum logic [2:0] {
		SEQ_IDLE,     // waiting for i_start
		SEQ_PRESCALE, // text into montgomery domain
		SEQ_LAUNCH,   // start lanes for current exponent bit
		SEQ_MULT,     // wait for every launched lane
		SEQ_UPDATE    // take square and product
	} seq_state_e;

	// shared by the pre-scaler and the montgomery lanes
	typedef enum logic [1:0] {
		UNIT_IDLE,
		UNIT_RUN,
		UNIT_FIX    // final conditional subtract
	} unit_state_e;

endpackage

// File: rtl/rsa_data_pkg.sv
`include "rsa_defines.svh"

package rsa_data_pkg;

	// lane 0 multiplies, lane 1 squares
	localparam int N_LANES  = 2;
	localparam int LANE_MUL = 0;
	localparam int LANE_SQR = 1;

	// operands handed to a montgomery lane
	typedef struct packed {
		logic [`RSA_W-1:0] a; // multiplicand
		logic [`RSA_W-1:0] b; // multiplier, consumed lsb first
	} mont_req_t;

	// a * b * 2^-256 mod n
	typedef struct packed {
		logic [`RSA_W-1:0] p;
	} mont_rsp_t;

endpackage

// File: rtl/rsa_prescale.sv
`timescale 1ns/1ns
`include "rsa_defines.svh"

module rsa_prescale
	import rsa_state_pkg::*;
(
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic              i_start,
	input  logic [`RSA_W-1:0] i_mod,
	input  logic [`RSA_W-1:0] i_val,
	output logic [`RSA_W-1:0] o_res,
	output logic              o_done
);

	localparam logic [`RSA_CNT_W-1:0] LAST_STEP = `RSA_CNT_W'(`RSA_W - 1);

	unit_state_e           state;
	logic [`RSA_CNT_W-1:0] step;
	logic [`RSA_W-1:0]     val_q;
	logic [`RSA_W:0]       dbl;   // one spare bit, value stays below 2n
	logic [`RSA_W:0]       diff;
	logic [`RSA_W-1:0]     val_nxt;

	assign dbl  = {val_q, 1'b0};
	assign diff = dbl - {1'b0, i_mod};

	// reduce once, input is always below n
	assign val_nxt = (dbl >= {1'b0, i_mod}) ? diff[`RSA_W-1:0] : dbl[`RSA_W-1:0];

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state <= UNIT_IDLE;
			step  <= '0;
		end else begin
			case (state)
				UNIT_IDLE: begin
					if (i_start) begin
						step  <= '0;
						state <= UNIT_RUN;
					end
				end
				UNIT_RUN: begin
					step <= step + 1'b1;
					if (step == LAST_STEP)
						state <= UNIT_FIX;
				end
				UNIT_FIX: state <= UNIT_IDLE; // result already reduced
				default:  state <= UNIT_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state == UNIT_IDLE && i_start)
			val_q <= i_val;
		else if (state == UNIT_RUN)
			val_q <= val_nxt; // 2*val mod n
	end

	assign o_res  = val_q;
	assign o_done = (state == UNIT_FIX);

endmodule

// File: rtl/rsa_mont.sv
`timescale 1ns/1ns
`include "rsa_defines.svh"

module rsa_mont
	import rsa_state_pkg::*;
	import rsa_data_pkg::*;
(
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic              i_start,
	input  logic [`RSA_W-1:0] i_mod,
	input  mont_req_t         i_req,
	output mont_rsp_t         o_rsp,
	output logic              o_done
);

	localparam logic [`RSA_CNT_W-1:0] LAST_STEP = `RSA_CNT_W'(`RSA_W - 1);

	unit_state_e           state;
	logic [`RSA_CNT_W-1:0] step;
	logic [`RSA_W-1:0]     a_q;
	logic [`RSA_W-1:0]     b_q;    // shifted right every step
	logic [`RSA_W:0]       acc;    // stays below 2n
	logic [`RSA_W+1:0]     sum_add;
	logic [`RSA_W+1:0]     sum_red;
	logic [`RSA_W:0]       acc_nxt;
	logic [`RSA_W:0]       acc_sub;
	logic                  acc_ge;

	// add a on a set multiplier bit
	assign sum_add = {1'b0, acc} + (b_q[0] ? {2'b00, a_q} : '0);
	// make it even before halving
	assign sum_red = sum_add + (sum_add[0] ? {2'b00, i_mod} : '0);
	assign acc_nxt = sum_red[`RSA_W+1:1];

	assign acc_sub = acc - {1'b0, i_mod};
	assign acc_ge  = (acc >= {1'b0, i_mod});

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state <= UNIT_IDLE;
			step  <= '0;
		end else begin
			case (state)
				UNIT_IDLE: begin
					if (i_start) begin
						step  <= '0;
						state <= UNIT_RUN;
					end
				end
				UNIT_RUN: begin
					step <= step + 1'b1;
					if (step == LAST_STEP)
						state <= UNIT_FIX;
				end
				UNIT_FIX: state <= UNIT_IDLE;
				default:  state <= UNIT_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state == UNIT_IDLE && i_start) begin
			a_q <= i_req.a;
			b_q <= i_req.b;
			acc <= '0;
		end else if (state == UNIT_RUN) begin
			b_q <= {1'b0, b_q[`RSA_W-1:1]};
			acc <= acc_nxt;
		end
	end

	// final subtract, acc is left alone after the run so this holds
	assign o_rsp.p = acc_ge ? acc_sub[`RSA_W-1:0] : acc[`RSA_W-1:0];
	assign o_done  = (state == UNIT_FIX);

endmodule

// File: rtl/rsa_exp_seq.sv
`timescale 1ns/1ns
`include "rsa_defines.svh"

module rsa_exp_seq
	import rsa_state_pkg::*;
	import rsa_data_pkg::*;
(
	input  logic               i_clk,
	input  logic               i_rst,
	input  logic               i_start,
	input  logic [`RSA_W-1:0]  i_text,
	input  logic [`RSA_W-1:0]  i_exp,
	output logic               o_pre_start,
	output logic [`RSA_W-1:0]  o_pre_val,
	input  logic [`RSA_W-1:0]  i_pre_res,
	input  logic               i_pre_done,
	output logic [N_LANES-1:0] o_lane_start,
	output mont_req_t          o_lane_req [N_LANES],
	input  mont_rsp_t          i_lane_rsp [N_LANES],
	input  logic [N_LANES-1:0] i_lane_done,
	output logic [`RSA_W-1:0]  o_result,
	output logic               o_done
);

	localparam int BIT_IW = $clog2(`RSA_W);
	localparam logic [`RSA_CNT_W-1:0] LAST_BIT = `RSA_CNT_W'(`RSA_W - 1);

	seq_state_e            state;
	logic [`RSA_CNT_W-1:0] bit_cnt; // exponent bit, lsb first
	logic                  exp_bit;
	logic [N_LANES-1:0]    need;    // lanes launched for this bit
	logic [N_LANES-1:0]    got;     // done pulses seen so far
	logic [N_LANES-1:0]    got_nxt;
	logic                  pre_start_q;
	logic                  done_q;
	logic [`RSA_W-1:0]     result_q;
	logic [`RSA_W-1:0]     text_q;
	logic [`RSA_W-1:0]     acc_q;   // plain domain
	logic [`RSA_W-1:0]     pow_q;   // montgomery domain
	mont_rsp_t             rsp_q [N_LANES];

	assign exp_bit = i_exp[bit_cnt[BIT_IW-1:0]];

	always_comb begin
		need           = '0;
		need[LANE_SQR] = 1'b1;    // square every bit
		need[LANE_MUL] = exp_bit;
	end

	assign got_nxt      = got | i_lane_done;
	assign o_lane_start = (state == SEQ_LAUNCH) ? need : '0;

	// acc * pow stays in plain domain since pow carries the 2^256 factor
	always_comb begin
		o_lane_req[LANE_MUL].a = acc_q;
		o_lane_req[LANE_MUL].b = pow_q;
		o_lane_req[LANE_SQR].a = pow_q;
		o_lane_req[LANE_SQR].b = pow_q;
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state       <= SEQ_IDLE;
			bit_cnt     <= '0;
			got         <= '0;
			pre_start_q <= 1'b0;
			done_q      <= 1'b0;
			result_q    <= '0;
		end else begin
			pre_start_q <= 1'b0;
			done_q      <= 1'b0;
			case (state)
				SEQ_IDLE: begin
					if (i_start) begin
						pre_start_q <= 1'b1;
						state       <= SEQ_PRESCALE;
					end
				end
				SEQ_PRESCALE: begin
					if (i_pre_done) begin
						bit_cnt <= '0;
						state   <= SEQ_LAUNCH;
					end
				end
				SEQ_LAUNCH: begin
					got   <= '0;
					state <= SEQ_MULT;
				end
				SEQ_MULT: begin
					got <= got_nxt;
					if ((got_nxt & need) == need)
						state <= SEQ_UPDATE;
				end
				SEQ_UPDATE: begin
					if (bit_cnt == LAST_BIT) begin
						result_q <= exp_bit ? rsp_q[LANE_MUL].p : acc_q;
						done_q   <= 1'b1;
						state    <= SEQ_IDLE;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
						state   <= SEQ_LAUNCH;
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state == SEQ_IDLE && i_start)
			text_q <= i_text;
		if (state == SEQ_PRESCALE && i_pre_done) begin
			pow_q <= i_pre_res;
			acc_q <= `RSA_W'(1);
		end
		for (int k = 0; k < N_LANES; k++) begin
			if (state == SEQ_MULT && i_lane_done[k])
				rsp_q[k] <= i_lane_rsp[k]; // lanes may finish in any order
		end
		if (state == SEQ_UPDATE) begin
			pow_q <= rsp_q[LANE_SQR].p;
			if (exp_bit)
				acc_q <= rsp_q[LANE_MUL].p;
		end
	end

	assign o_pre_start = pre_start_q;
	assign o_pre_val   = text_q;
	assign o_result    = result_q;
	assign o_done      = done_q;

endmodule

// File: rtl/rsa256_top.sv
`timescale 1ns/1ns
`include "rsa_defines.svh"

module rsa256_top
	import rsa_data_pkg::*;
(
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic              i_start,
	input  logic [`RSA_W-1:0] i_text,
	input  logic [`RSA_W-1:0] i_exp,
	input  logic [`RSA_W-1:0] i_mod,
	output logic [`RSA_W-1:0] o_result,
	output logic              o_done
);

	logic               pre_start;
	logic [`RSA_W-1:0]  pre_val;
	logic [`RSA_W-1:0]  pre_res;
	logic               pre_done;
	logic [N_LANES-1:0] lane_start;
	logic [N_LANES-1:0] lane_done;
	mont_req_t          lane_req [N_LANES];
	mont_rsp_t          lane_rsp [N_LANES];

	rsa_prescale u_prescale (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (pre_start),
		.i_mod   (i_mod),
		.i_val   (pre_val),
		.o_res   (pre_res),
		.o_done  (pre_done)
	);

	rsa_exp_seq u_seq (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_start      (i_start),
		.i_text       (i_text),
		.i_exp        (i_exp),
		.o_pre_start  (pre_start),
		.o_pre_val    (pre_val),
		.i_pre_res    (pre_res),
		.i_pre_done   (pre_done),
		.o_lane_start (lane_start),
		.o_lane_req   (lane_req),
		.i_lane_rsp   (lane_rsp),
		.i_lane_done  (lane_done),
		.o_result     (o_result),
		.o_done       (o_done)
	);

	// lane 0 multiply, lane 1 square
	for (genvar g = 0; g < N_LANES; g++) begin : g_lane
		rsa_mont u_mont (
			.i_clk   (i_clk),
			.i_rst   (i_rst),
			.i_start (lane_start[g]),
			.i_mod   (i_mod),
			.i_req   (lane_req[g]),
			.o_rsp   (lane_rsp[g]),
			.o_done  (lane_done[g])
		);
	end

endmodule

// File: verif/rsa_chk.sv
`timescale 1ns/1ns

module rsa_chk
	import rsa_state_pkg::*;
(
	input logic        i_clk,
	input logic        i_rst,
	input logic        i_done,
	input seq_state_e  i_seq_state,
	input unit_state_e i_mul_state,
	input unit_state_e i_sqr_state
);

	// done is a single-cycle pulse
	property p_done_single;
		@(posedge i_clk) disable iff (i_rst)
		i_done |=> !i_done;
	endproperty

	// every lane has drained by the time the next bit is launched
	property p_launch_lanes_idle;
		@(posedge i_clk) disable iff (i_rst)
		(i_seq_state == SEQ_LAUNCH) |->
			(i_mul_state == UNIT_IDLE && i_sqr_state == UNIT_IDLE);
	endproperty

	a_done_single: assert property (p_done_single)
		else $error("o_done stayed high for two cycles");

	a_launch_lanes_idle: assert property (p_launch_lanes_idle)
		else $error("a lane was still busy when the sequencer entered SEQ_LAUNCH");

endmodule

bind rsa256_top rsa_chk u_chk (
	.i_clk       (i_clk),
	.i_rst       (i_rst),
	.i_done      (o_done),
	.i_seq_state (u_seq.state),
	.i_mul_state (g_lane[0].u_mont.state),
	.i_sqr_state (g_lane[1].u_mont.state)
);

// File: verif/rsa_mon.sv
`timescale 1ns/1ns
`include "rsa_defines.svh"

module rsa_mon (
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic              i_start,
	input  logic [`RSA_W-1:0] i_text,
	input  logic [`RSA_W-1:0] i_exp,
	input  logic [`RSA_W-1:0] i_mod,
	input  logic [`RSA_W-1:0] i_result,
	input  logic              i_done,
	output int                o_pass_cnt,
	output int                o_fail_cnt
);

	localparam int TIMEOUT = 200000;

	logic              busy;
	logic              seen_start; // idle check ends at first start
	logic              idle_bad;
	logic [`RSA_W-1:0] text_q;
	logic [`RSA_W-1:0] exp_q;
	logic [`RSA_W-1:0] mod_q;
	int                job_n;
	int                wait_cnt;

	// shift and subtract, a below n
	function automatic logic [`RSA_W-1:0] mod_mul(input logic [`RSA_W-1:0] a,
		input logic [`RSA_W-1:0] b, input logic [`RSA_W-1:0] n);
		logic [`RSA_W:0] r;
		r = '0;
		for (int i = `RSA_W - 1; i >= 0; i--) begin
			r = {r[`RSA_W-1:0], 1'b0};
			if (r >= {1'b0, n})
				r = r - {1'b0, n};
			if (b[i])
				r = r + {1'b0, a};
			if (r >= {1'b0, n})
				r = r - {1'b0, n};
		end
		return r[`RSA_W-1:0];
	endfunction

	// square and multiply, lsb first
	function automatic logic [`RSA_W-1:0] mod_exp(input logic [`RSA_W-1:0] base,
		input logic [`RSA_W-1:0] e, input logic [`RSA_W-1:0] n);
		logic [`RSA_W-1:0] acc;
		logic [`RSA_W-1:0] pw;
		acc = `RSA_W'(1);
		pw  = base;
		for (int i = 0; i < `RSA_W; i++) begin
			if (e[i])
				acc = mod_mul(acc, pw, n);
			pw = mod_mul(pw, pw, n);
		end
		return acc;
	endfunction

	task automatic check_idle();
		if (i_done !== 1'b0) begin
			$display("error at %0t ns: o_done expected 0 got %b", $time, i_done);
			idle_bad = 1'b1;
		end else if (i_result !== '0) begin
			$display("error at %0t ns: o_result expected 0 got %0h", $time, i_result);
			idle_bad = 1'b1;
		end
		if (idle_bad)
			o_fail_cnt++;
	endtask

	task automatic finish_job();
		logic [`RSA_W-1:0] want;
		if (!busy) begin
			$display("unexpected o_done at %0t ns with no job running", $time);
			o_fail_cnt++;
		end else begin
			want = mod_exp(text_q, exp_q, mod_q);
			busy = 1'b0;
			if (i_result !== want) begin
				$display("error at %0t ns, job %0d: o_result expected %0h got %0h",
					$time, job_n, want, i_result);
				o_fail_cnt++;
			end else begin
				$display("job %0d pass: o_result %0h", job_n, i_result);
				o_pass_cnt++;
			end
		end
	endtask

	task automatic accept_job();
		text_q   = i_text;
		exp_q    = i_exp;
		mod_q    = i_mod;
		busy     = 1'b1;
		wait_cnt = 0;
		job_n++;
		if (!seen_start) begin
			seen_start = 1'b1;
			if (!idle_bad) begin
				$display("reset idle check pass: o_done low, o_result zero");
				o_pass_cnt++;
			end
		end
	endtask

	task automatic watch_timeout();
		wait_cnt++;
		if (wait_cnt >= TIMEOUT) begin
			$display("timeout: job %0d got no o_done within %0d cycles", job_n, TIMEOUT);
			o_fail_cnt++;
			busy = 1'b0;
		end
	endtask

	always @(posedge i_clk) begin
		if (i_rst) begin
			busy       = 1'b0;
			seen_start = 1'b0;
			idle_bad   = 1'b0;
			job_n      = 0;
			wait_cnt   = 0;
			o_pass_cnt = 0;
			o_fail_cnt = 0;
		end else begin
			if (!seen_start && !idle_bad)
				check_idle();
			if (i_done)
				finish_job(); // engine is idle again on this edge
			if (i_start && !busy)
				accept_job();
			else if (busy)
				watch_timeout();
		end
	end

endmodule

// File: verif/rsa_tb.sv
`timescale 1ns/1ns
`include "rsa_defines.svh"

module rsa_tb;

	localparam int          TIMEOUT  = 200000;
	localparam int          TB_LIMIT = TIMEOUT + 4; // monitor reports first
	localparam logic [31:0] SEED     = 32'hdc9870b1;

	logic              clk;
	logic              rst;
	logic              start;
	logic [`RSA_W-1:0] text;
	logic [`RSA_W-1:0] key_exp;
	logic [`RSA_W-1:0] key_mod;
	logic [`RSA_W-1:0] result;
	logic              done;
	logic [31:0]       lfsr;
	logic              stalled; // a job never finished
	int                pass_cnt;
	int                fail_cnt;
	logic [`RSA_W-1:0] r_text;
	logic [`RSA_W-1:0] r_exp;
	logic [`RSA_W-1:0] r_mod;

	always #50 clk = ~clk;

	rsa256_top i_rsa256_top (
		.i_clk    (clk),
		.i_rst    (rst),
		.i_start  (start),
		.i_text   (text),
		.i_exp    (key_exp),
		.i_mod    (key_mod),
		.o_result (result),
		.o_done   (done)
	);

	rsa_mon u_mon (
		.i_clk      (clk),
		.i_rst      (rst),
		.i_start    (start),
		.i_text     (text),
		.i_exp      (key_exp),
		.i_mod      (key_mod),
		.i_result   (result),
		.i_done     (done),
		.o_pass_cnt (pass_cnt),
		.o_fail_cnt (fail_cnt)
	);

	// fibonacci, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_word(output logic [`RSA_W-1:0] w);
		for (int i = 0; i < `RSA_W; i++) begin
			lfsr = lfsr_step(lfsr);
			w[i] = lfsr[0]; // one step per bit
		end
	endtask

	task automatic rand_operands(output logic [`RSA_W-1:0] t, output logic [`RSA_W-1:0] m);
		rand_word(m);
		m[`RSA_W-1] = 1'b1;
		m[0]        = 1'b1;
		rand_word(t);
		t[`RSA_W-1] = 1'b0; // keeps text below n
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic pulse_start(input logic [`RSA_W-1:0] t, input logic [`RSA_W-1:0] e,
		input logic [`RSA_W-1:0] m);
		@(negedge clk);
		text    = t;
		key_exp = e;
		key_mod = m;
		start   = 1'b1;
		@(negedge clk);
		start   = 1'b0;
	endtask

	task automatic wait_done();
		int n;
		for (n = 0; n < TB_LIMIT; n++) begin
			@(negedge clk);
			if (done)
				break;
		end
		if (n == TB_LIMIT) begin
			$display("run stopped: the DUT did not finish a job in time");
			stalled = 1'b1;
		end
	endtask

	task automatic run_job(input logic [`RSA_W-1:0] t, input logic [`RSA_W-1:0] e,
		input logic [`RSA_W-1:0] m);
		if (stalled)
			return;
		pulse_start(t, e, m);
		wait_done();
	endtask

	// second start mid-job must be dropped
	task automatic run_busy_job(input logic [`RSA_W-1:0] t, input logic [`RSA_W-1:0] e,
		input logic [`RSA_W-1:0] m);
		if (stalled)
			return;
		pulse_start(t, e, m);
		idle_cycles(40);
		pulse_start(t ^ 256'h3c3c_5a5a, e, m); // exp and mod held
		wait_done();
		idle_cycles(1000); // monitor flags any extra o_done
	endtask

	initial begin
		clk     = 1'b0;
		rst     = 1'b1;
		start   = 1'b0;
		text    = '0;
		key_exp = '0;
		key_mod = '0;
		lfsr    = SEED;
		stalled = 1'b0;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		idle_cycles(20); // outputs must stay quiet here

		rand_operands(r_text, r_mod);
		run_job(r_text, `RSA_W'(0), r_mod);
		run_job(r_text, `RSA_W'(1), r_mod);

		// textbook key, n = 61 * 53
		run_job(`RSA_W'(65), `RSA_W'(17), `RSA_W'(3233));
		run_job(`RSA_W'(2790), `RSA_W'(2753), `RSA_W'(3233));

		for (int k = 0; k < 8; k++) begin
			rand_operands(r_text, r_mod);
			rand_word(r_exp);
			run_job(r_text, r_exp, r_mod);
		end

		rand_operands(r_text, r_mod);
		rand_word(r_exp);
		run_busy_job(r_text, r_exp, r_mod);

		@(negedge clk);
		$display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && !stalled)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: tb.f
+incdir+rtl
rtl/rsa_state_pkg.sv
rtl/rsa_data_pkg.sv
rtl/rsa_prescale.sv
rtl/rsa_mont.sv
rtl/rsa_exp_seq.sv
rtl/rsa256_top.sv
verif/rsa_chk.sv
verif/rsa_mon.sv
verif/rsa_tb.sv

// File: Makefile
TOP := rsa_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir -o sim_rsa
	-./obj_dir/sim_rsa > sim.log 2>&1
	cat sim.log
	@if grep -q "RESULT: FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" sim.log; then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
